//--- logic/core_pkg.sv
package core_pkg;

    // ------------------------------
    // Widths and fixed addresses
    // ------------------------------
    localparam int XLEN       = 32;
    localparam int DMEM_WORDS = 256;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [7:0]      dmem_addr_t;

    localparam word_t EXIT_PC = 32'h0000_0044;  // Write-back pc that ends a test program.

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_fn_e;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

    typedef enum logic [2:0] {
        WB_ALU, WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW, WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {FWD_REG, FWD_FROM_MEM, FWD_FROM_WB} fwd_sel_e;

    // ------------------------------
    // Pipeline records
    // ------------------------------
    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_fn_e   alu_fn;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        logic      use_imm;
        mem_op_e   mem_op;
        mem_size_e mem_size;  // Only stores look at this. Loads size by wb_sel.
        wb_sel_e   wb_sel;
        logic      rf_wen;
        reg_addr_t rd;
    } uop_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     alu_out;
        word_t     store_data;
        mem_op_e   mem_op;
        mem_size_e mem_size;
        wb_sel_e   wb_sel;
        logic      rf_wen;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     alu_out;  // Low two bits still hold the byte offset of a load.
        word_t     mem_rdata;
        wb_sel_e   wb_sel;
        logic      rf_wen;
        reg_addr_t rd;
    } mem_wb_t;

endpackage

//--- logic/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  uop_t     ex_uop_i,
    input  ex_mem_t  ex_mem_i,
    input  mem_wb_t  mem_wb_i,
    output fwd_sel_e fwd_a_o,
    output fwd_sel_e fwd_b_o,
    output logic     retire_o,
    output logic     exit_o,
    output word_t    retire_count_o
);

    word_t retire_count_q;

    // ------------------------------
    // Forwarding
    // ------------------------------
    function automatic fwd_sel_e pick_fwd(input reg_addr_t src);
        if (src == '0) begin
            return FWD_REG;  // x0 is constant, nothing to bypass.
        end else if (ex_mem_i.valid && ex_mem_i.rf_wen && ex_mem_i.rd == src) begin
            return FWD_FROM_MEM;  // Newest producer wins.
        end else if (mem_wb_i.valid && mem_wb_i.rf_wen && mem_wb_i.rd == src) begin
            return FWD_FROM_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = pick_fwd(ex_uop_i.rs1);
        fwd_b_o = pick_fwd(ex_uop_i.rs2);
    end

    // ------------------------------
    // Retire and exit
    // ------------------------------
    assign retire_o = mem_wb_i.valid;
    assign exit_o   = mem_wb_i.valid && (mem_wb_i.pc == EXIT_PC);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_count_q <= '0;
        end else if (retire_o) begin
            retire_count_q <= retire_count_q + word_t'(1);
        end
    end

    assign retire_count_o = retire_count_q;

    // A load result only exists after MEM, so its consumer must not sit right behind it.
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(ex_uop_i.valid && ex_mem_i.valid && ex_mem_i.mem_op == MEM_LOAD
          && ex_mem_i.rf_wen && ex_mem_i.rd != '0
          && (ex_uop_i.rs1 == ex_mem_i.rd
              || ((!ex_uop_i.use_imm || ex_uop_i.mem_op == MEM_STORE)
                  && ex_uop_i.rs2 == ex_mem_i.rd))))
        else $error("** Error: load-use hazard on ex_mem_i.rd 0x%h", ex_mem_i.rd);

    // Every retirement was a valid instruction in MEM one cycle before.
    assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_o |-> $past(ex_mem_i.valid))
        else $error("** Error: retire_o without a valid instruction, pc 0x%h", mem_wb_i.pc);

endmodule

//--- logic/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  uop_t     issue_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    input  fwd_sel_e fwd_a_i,
    input  fwd_sel_e fwd_b_i,
    input  word_t    mem_fwd_i,
    input  word_t    wb_fwd_i,
    output uop_t     ex_uop_o,
    output ex_mem_t  ex_mem_o
);

    logic    ex_valid_q;
    uop_t    ex_payload_q;
    uop_t    ex_uop;
    word_t   rs1_val;
    word_t   rs2_val;
    word_t   op_b;
    word_t   alu_out;
    logic    ex_mem_valid_q;
    ex_mem_t ex_mem_payload_q;

    // ------------------------------
    // EX register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= issue_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_payload_q <= issue_i;
    end

    always_comb begin
        ex_uop       = ex_payload_q;
        ex_uop.valid = ex_valid_q;
    end

    assign ex_uop_o = ex_uop;

    // ------------------------------
    // Operands and ALU
    // ------------------------------
    assign rs1_val = (fwd_a_i == FWD_FROM_MEM) ? mem_fwd_i :
                     (fwd_a_i == FWD_FROM_WB)  ? wb_fwd_i  : rs1_data_i;
    assign rs2_val = (fwd_b_i == FWD_FROM_MEM) ? mem_fwd_i :
                     (fwd_b_i == FWD_FROM_WB)  ? wb_fwd_i  : rs2_data_i;
    assign op_b    = ex_uop.use_imm ? ex_uop.imm : rs2_val;

    always_comb begin
        case (ex_uop.alu_fn)
            ALU_SUB:    alu_out = rs1_val - op_b;
            ALU_AND:    alu_out = rs1_val & op_b;
            ALU_OR:     alu_out = rs1_val | op_b;
            ALU_XOR:    alu_out = rs1_val ^ op_b;
            ALU_SLL:    alu_out = rs1_val << op_b[4:0];
            ALU_SRL:    alu_out = rs1_val >> op_b[4:0];
            ALU_SRA:    alu_out = word_t'($signed(rs1_val) >>> op_b[4:0]);
            ALU_SLT:    alu_out = word_t'($signed(rs1_val) < $signed(op_b));
            ALU_SLTU:   alu_out = word_t'(rs1_val < op_b);
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = rs1_val + op_b;  // Also the address adder for loads and stores.
        endcase
    end

    // ------------------------------
    // EX/MEM register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_valid_q <= 1'b0;
        end else begin
            ex_mem_valid_q <= ex_uop.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_payload_q.pc         <= ex_uop.pc;
        ex_mem_payload_q.alu_out    <= alu_out;
        ex_mem_payload_q.store_data <= rs2_val;  // Forwarded rs2, not the immediate.
        ex_mem_payload_q.mem_op     <= ex_uop.mem_op;
        ex_mem_payload_q.mem_size   <= ex_uop.mem_size;
        ex_mem_payload_q.wb_sel     <= ex_uop.wb_sel;
        ex_mem_payload_q.rf_wen     <= ex_uop.rf_wen;
        ex_mem_payload_q.rd         <= ex_uop.rd;
        ex_mem_payload_q.valid      <= 1'b1;
    end

    always_comb begin
        ex_mem_o       = ex_mem_payload_q;
        ex_mem_o.valid = ex_mem_valid_q;
    end

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  ex_mem_t ex_mem_i,
    output mem_wb_t mem_wb_o
);

    word_t      dmem [DMEM_WORDS];
    dmem_addr_t word_idx;
    logic [1:0] lane;
    logic [3:0] byte_en;
    word_t      wdata;
    logic       mem_wb_valid_q;
    mem_wb_t    mem_wb_payload_q;

    assign word_idx = ex_mem_i.alu_out[9:2];
    assign lane     = ex_mem_i.alu_out[1:0];

    // ------------------------------
    // Store lanes
    // ------------------------------
    always_comb begin
        case (ex_mem_i.mem_size)
            SIZE_BYTE: begin
                byte_en = 4'b0001 << lane;
                wdata   = {4{ex_mem_i.store_data[7:0]}};
            end
            SIZE_HALF: begin
                byte_en = 4'b0011 << lane;
                wdata   = {2{ex_mem_i.store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wdata   = ex_mem_i.store_data;
            end
        endcase
    end

    // Read and write share the edge; the read returns the word as it was before.
    always_ff @(posedge clk) begin
        if (ex_mem_i.valid && ex_mem_i.mem_op == MEM_STORE) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    dmem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        mem_wb_payload_q.mem_rdata <= dmem[word_idx];
        mem_wb_payload_q.pc        <= ex_mem_i.pc;
        mem_wb_payload_q.alu_out   <= ex_mem_i.alu_out;
        mem_wb_payload_q.wb_sel    <= ex_mem_i.wb_sel;
        mem_wb_payload_q.rf_wen    <= ex_mem_i.rf_wen;
        mem_wb_payload_q.rd        <= ex_mem_i.rd;
        mem_wb_payload_q.valid     <= 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wb_valid_q <= 1'b0;
        end else begin
            mem_wb_valid_q <= ex_mem_i.valid;
        end
    end

    always_comb begin
        mem_wb_o       = mem_wb_payload_q;
        mem_wb_o.valid = mem_wb_valid_q;
    end

    // Loads size by wb_sel, stores by mem_size.
    assert property (@(posedge clk) disable iff (!rst_n_i)
        ex_mem_i.valid && ex_mem_i.mem_op != MEM_NONE |->
            !(((ex_mem_i.mem_op == MEM_STORE && ex_mem_i.mem_size == SIZE_HALF)
               || (ex_mem_i.mem_op == MEM_LOAD
                   && (ex_mem_i.wb_sel == WB_MEMH || ex_mem_i.wb_sel == WB_MEMHU)))
              && lane[0])
            && !(((ex_mem_i.mem_op == MEM_STORE && ex_mem_i.mem_size == SIZE_WORD)
                  || (ex_mem_i.mem_op == MEM_LOAD && ex_mem_i.wb_sel == WB_MEMW))
                 && lane != 2'b00))
        else $error("** Error: misaligned access, alu_out 0x%h", ex_mem_i.alu_out);

endmodule

//--- logic/wb_stage.sv
`timescale 1ns/1ps

module wb_stage import core_pkg::*; (
    input  mem_wb_t   mem_wb_i,
    output word_t     wb_data_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o
);

    word_t lane_data;

    // ------------------------------
    // Load alignment
    // ------------------------------
    // Bring the addressed byte or half-word down to bit 0 before extension.
    assign lane_data = mem_wb_i.mem_rdata >> {mem_wb_i.alu_out[1:0], 3'b000};

    // ------------------------------
    // Result select
    // ------------------------------
    always_comb begin
        case (mem_wb_i.wb_sel)
            WB_MEMB: begin
                wb_data_o = {{24{lane_data[7]}}, lane_data[7:0]};
            end
            WB_MEMBU: begin
                wb_data_o = {24'b0, lane_data[7:0]};
            end
            WB_MEMH: begin
                wb_data_o = {{16{lane_data[15]}}, lane_data[15:0]};
            end
            WB_MEMHU: begin
                wb_data_o = {16'b0, lane_data[15:0]};
            end
            WB_MEMW: begin
                wb_data_o = mem_wb_i.mem_rdata;
            end
            WB_PC4: begin
                wb_data_o = mem_wb_i.pc + word_t'(4);  // Link value for jumps.
            end
            default: begin
                wb_data_o = mem_wb_i.alu_out;
            end
        endcase
    end

    // ------------------------------
    // Register file write port
    // ------------------------------
    assign wb_we_o   = mem_wb_i.valid && mem_wb_i.rf_wen;
    assign wb_addr_o = mem_wb_i.rd;  // The register file drops writes to x0.

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t ra_i,
    input  reg_addr_t rb_i,
    input  reg_addr_t rd_addr_i,  // Destination of the instruction now in EX.
    output word_t     ra_data_o,
    output word_t     rb_data_o,
    input  logic      we_i,
    input  reg_addr_t wa_i,
    input  word_t     wd_i,
    input  reg_addr_t dbg_addr_i,
    output word_t     dbg_data_o
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // Reads return the old value in the write cycle.
    assign ra_data_o  = (ra_i == '0) ? '0 : regs[ra_i];
    assign rb_data_o  = (rb_i == '0) ? '0 : regs[rb_i];
    assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs[dbg_addr_i];

    // The rd written now must be the one that left EX two edges ago.
    assert property (@(posedge clk) disable iff (!rst_n_i)
        we_i |-> wa_i == $past(rd_addr_i, 2))
        else $error("** Error: wa_i 0x%h does not match the rd seen in EX", wa_i);

endmodule

//--- logic/backend_top.sv
`timescale 1ns/1ps

module backend_top import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  uop_t      issue_i,
    input  reg_addr_t dbg_addr_i,
    output word_t     dbg_data_o,
    output logic      retire_o,
    output logic      exit_o,
    output word_t     retire_count_o
);

    uop_t      ex_uop;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     wb_data;
    logic      wb_we;
    reg_addr_t wb_addr;

    // ------------------------------
    // Control
    // ------------------------------
    pipe_ctrl pipe_ctrl_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ex_uop_i       (ex_uop),
        .ex_mem_i       (ex_mem),
        .mem_wb_i       (mem_wb),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b),
        .retire_o       (retire_o),
        .exit_o         (exit_o),
        .retire_count_o (retire_count_o)
    );

    // ------------------------------
    // Datapath
    // ------------------------------
    exec_stage exec_stage_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .issue_i    (issue_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .fwd_a_i    (fwd_a),
        .fwd_b_i    (fwd_b),
        .mem_fwd_i  (ex_mem.alu_out),  // MEM bypass carries the ALU result only.
        .wb_fwd_i   (wb_data),
        .ex_uop_o   (ex_uop),
        .ex_mem_o   (ex_mem)
    );

    mem_stage mem_stage_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ex_mem_i (ex_mem),
        .mem_wb_o (mem_wb)
    );

    wb_stage wb_stage_i (
        .mem_wb_i  (mem_wb),
        .wb_data_o (wb_data),
        .wb_we_o   (wb_we),
        .wb_addr_o (wb_addr)
    );

    reg_file reg_file_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ra_i       (ex_uop.rs1),
        .rb_i       (ex_uop.rs2),
        .rd_addr_i  (ex_uop.rd),
        .ra_data_o  (rs1_data),
        .rb_data_o  (rs2_data),
        .we_i       (wb_we),
        .wa_i       (wb_addr),
        .wd_i       (wb_data),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o)
    );

endmodule

//--- dv/backend_tb.sv
`timescale 1ns/1ps

module backend_tb import core_pkg::*; ();

    logic       clk;
    logic       rst_n_i;
    uop_t       issue_i;
    reg_addr_t  dbg_addr_i;
    word_t      dbg_data_o;
    logic       retire_o;
    logic       exit_o;
    word_t      retire_count_o;

    word_t      model_regs [32];
    logic [7:0] model_bytes [1024];  // Byte-addressed data memory model.
    uop_t       issue_hist [3];  // The issue_i seen at the last three edges, newest first.
    logic       exp_retire;
    logic       exp_exit;
    word_t      rng_state = 32'h4560_5980;
    word_t      next_pc = 32'h0000_1000;
    word_t      issued = '0;
    int         errors = 0;
    int         tests = 0;
    int         exits = 0;

    backend_top backend_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // Pipeline timing checks
    // ------------------------------
    assign exp_retire = issue_hist[2].valid;  // An issue sits in WB three edges later.
    assign exp_exit   = issue_hist[2].valid && (issue_hist[2].pc == EXIT_PC);

    always @(posedge clk) begin
        if (rst_n_i) begin
            assert (retire_o === exp_retire)
                else begin
                    errors++;
                    $display("** Error: retire_o 0x%h expected 0x%h", retire_o, exp_retire);
                end
            assert (exit_o === exp_exit)
                else begin
                    errors++;
                    $display("** Error: exit_o 0x%h expected 0x%h", exit_o, exp_exit);
                end
        end
        issue_hist[2] <= issue_hist[1];
        issue_hist[1] <= issue_hist[0];
        issue_hist[0] <= issue_i;
    end

    always @(posedge clk) begin
        if (exit_o) exits++;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic word_t xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic word_t alu_model(alu_fn_e fn, word_t a, word_t b);
        case (fn)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
            ALU_SLT:  return (a[31] != b[31]) ? {31'h0, a[31]} : {31'h0, a < b};
            ALU_SLTU: return {31'h0, a < b};
            default:  return b;
        endcase
    endfunction

    // Little endian: the byte at the load address lands in bits 7:0.
    function automatic word_t load_model(wb_sel_e sel, logic [9:0] a);
        word_t raw;
        raw = {model_bytes[a + 10'd3], model_bytes[a + 10'd2], model_bytes[a + 10'd1],
               model_bytes[a]};
        case (sel)
            WB_MEMB:  return {{24{raw[7]}}, raw[7:0]};
            WB_MEMBU: return {24'h0, raw[7:0]};
            WB_MEMH:  return {{16{raw[15]}}, raw[15:0]};
            WB_MEMHU: return {16'h0, raw[15:0]};
            default:  return raw;
        endcase
    endfunction

    function automatic uop_t make_uop(alu_fn_e fn, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                                      logic use_imm, word_t imm, mem_op_e op, mem_size_e size,
                                      wb_sel_e sel);
        uop_t u;
        u          = '0;
        u.valid    = 1'b1;
        u.alu_fn   = fn;
        u.rs1      = rs1;
        u.rs2      = rs2;
        u.imm      = imm;
        u.use_imm  = use_imm;
        u.mem_op   = op;
        u.mem_size = size;
        u.wb_sel   = sel;
        u.rf_wen   = (op != MEM_STORE);
        u.rd       = rd;
        return u;
    endfunction

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic exec_uop(input uop_t u);
        word_t a;
        word_t b;
        u.pc = next_pc;
        next_pc += 32'd4;
        a = model_regs[u.rs1];
        b = u.use_imm ? u.imm : model_regs[u.rs2];
        if (u.mem_op == MEM_STORE) begin
            for (int i = 0; i < (1 << u.mem_size); i++) begin
                model_bytes[10'(a + u.imm + word_t'(i))] = 8'(model_regs[u.rs2] >> (8 * i));
            end
        end else if (u.rd != '0) begin
            model_regs[u.rd] = (u.mem_op == MEM_LOAD) ? load_model(u.wb_sel, 10'(a + u.imm))
                             : (u.wb_sel == WB_PC4) ? u.pc + 32'd4 : alu_model(u.alu_fn, a, b);
        end
        @(posedge clk);
        #1;
        issue_i = u;
        issued++;
    endtask

    task automatic load_imm(input reg_addr_t rd, input word_t value);
        exec_uop(make_uop(ALU_PASS_B, rd, 5'd0, 5'd0, 1'b1, value, MEM_NONE, SIZE_WORD, WB_ALU));
    endtask

    task automatic bubble();
        @(posedge clk);
        #1;
        issue_i = '0;
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s did not happen within the wait limit", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        bubble();
        while (retire_count_o != issued && waited < 10) begin
            bubble();
            waited++;
        end
        if (retire_count_o != issued) begin
            abort_run("pipeline drain");
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            dbg_addr_i = reg_addr_t'(r);
            #1;
            assert (dbg_data_o === model_regs[r])
                else begin
                    errors++;
                    $display("** Error: dbg_data_o x%0d 0x%h expected 0x%h",
                             r, dbg_data_o, model_regs[r]);
                end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("%s: %0d error(s)", name, errors - errs_before);
    endtask

    initial begin
        int        mark;
        int        waited;
        int        n;
        int        step;
        reg_addr_t prev;
        reg_addr_t older;
        reg_addr_t dst;
        wb_sel_e   sel;
        issue_i    = '0;
        dbg_addr_i = '0;
        rst_n_i    = 1'b0;
        model_regs = '{default: '0};
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        mark = errors;
        assert (retire_o === 1'b0 && exit_o === 1'b0 && retire_count_o === '0)
            else begin
                errors++;
                $display("** Error: after reset retire_o 0x%h exit_o 0x%h retire_count_o 0x%h",
                         retire_o, exit_o, retire_count_o);
            end
        check_regs();
        end_test("reset values", mark);

        // Each op reads the previous result (MEM bypass) and the one before it (WB bypass).
        mark  = errors;
        for (int r = 1; r < 5; r++) begin
            load_imm(reg_addr_t'(r), xorshift());
        end
        prev  = 5'd4;
        older = 5'd3;
        for (int k = 0; k < 22; k++) begin
            dst = reg_addr_t'(5 + k % 8);
            exec_uop(make_uop(alu_fn_e'(k % 11), dst, prev, older, k >= 11, xorshift(),
                              MEM_NONE, SIZE_WORD, WB_ALU));
            older = prev;
            prev  = dst;
        end
        drain();
        check_regs();
        end_test("alu chain with forwarding", mark);

        mark = errors;
        load_imm(5'd10, 32'h0000_0200);
        for (int k = 0; k < 4; k++) begin
            load_imm(5'd11, xorshift());
            exec_uop(make_uop(ALU_ADD, 5'd0, 5'd10, 5'd11, 1'b1, word_t'(4 * k),
                              MEM_STORE, SIZE_WORD, WB_ALU));
            load_imm(5'd11, xorshift());
            exec_uop(make_uop(ALU_ADD, 5'd0, 5'd10, 5'd11, 1'b1, word_t'(5 * k),
                              MEM_STORE, SIZE_BYTE, WB_ALU));
            load_imm(5'd11, xorshift());
            exec_uop(make_uop(ALU_ADD, 5'd0, 5'd10, 5'd11, 1'b1, word_t'(4 * k + 2 * (k % 2)),
                              MEM_STORE, SIZE_HALF, WB_ALU));
            n = 0;
            for (int s = 1; s <= 5; s++) begin
                sel  = wb_sel_e'(s);
                step = (sel == WB_MEMW) ? 4 : ((sel == WB_MEMH || sel == WB_MEMHU) ? 2 : 1);
                for (int off = 0; off < 4; off += step) begin
                    exec_uop(make_uop(ALU_ADD, reg_addr_t'(12 + n), 5'd10, 5'd0, 1'b1,
                                      word_t'(4 * k + off), MEM_LOAD, SIZE_WORD, sel));
                    n++;
                end
            end
            bubble();  // Keeps the last load out of MEM when the add below reads it.
            exec_uop(make_uop(ALU_ADD, 5'd25, 5'd24, 5'd23, 1'b0, '0, MEM_NONE, SIZE_WORD, WB_ALU));
            drain();
            check_regs();
        end
        end_test("stores and loads by lane", mark);

        mark = errors;
        exec_uop(make_uop(ALU_ADD, 5'd26, 5'd0, 5'd0, 1'b0, '0, MEM_NONE, SIZE_WORD, WB_PC4));
        load_imm(5'd0, xorshift());
        exec_uop(make_uop(ALU_ADD, 5'd0, 5'd0, 5'd0, 1'b0, '0, MEM_NONE, SIZE_WORD, WB_PC4));
        exec_uop(make_uop(ALU_OR, 5'd27, 5'd0, 5'd26, 1'b0, '0, MEM_NONE, SIZE_WORD, WB_ALU));
        drain();
        check_regs();
        end_test("pc4 and x0", mark);

        mark = errors;
        for (int k = 0; k < 6; k++) begin
            load_imm(5'd28, word_t'(k));
            bubble();
        end
        drain();
        repeat (4) bubble();
        assert (retire_count_o === issued)
            else begin
                errors++;
                $display("** Error: retire_count_o 0x%h expected 0x%h", retire_count_o, issued);
            end
        end_test("retire count", mark);

        mark    = errors;
        next_pc = EXIT_PC - 32'd8;
        for (int k = 0; k < 4; k++) begin
            load_imm(5'd29, word_t'(k));
        end
        waited = 0;
        while (!exit_o && waited < 10) begin
            bubble();
            waited++;
        end
        if (!exit_o) begin
            abort_run("exit_o rising");
        end
        drain();
        assert (exits == 1)
            else begin
                errors++;
                $display("exit_o was high for %0d cycles instead of one", exits);
            end
        end_test("exit flag", mark);

        $display("Tests run %0d, instructions %0d, errors %0d", tests, issued, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/core_pkg.sv
logic/pipe_ctrl.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/reg_file.sv
logic/backend_top.sv
dv/backend_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= backend_tb
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
